//--- build.f
+incdir+design
design/cache_addr_pkg.sv
design/cache_bus_pkg.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_ctrl.sv
design/cache_top.sv
verif/tb_mem_model.sv
verif/cache_tb.sv

//--- design/cache_addr_pkg.sv
// cache address fields and the stored tag entry layout
`default_nettype none

`include "cache_params.svh"

package cache_addr_pkg;

    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [$clog2(`CACHE_SETS)-1:0] index_t;
    typedef logic [$clog2(`CACHE_BEATS * `CACHE_STRB_W)-1:0] offset_t;  // byte in line
    typedef logic [$clog2(`CACHE_BEATS)-1:0] word_sel_t;                // word in line
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

    // one way of one set as held in the tag array
    typedef struct packed {
        logic valid;
        logic dirty;  // line differs from memory
        tag_t tag;
    } tag_entry_t;

endpackage

`default_nettype wire

//--- design/cache_bus_pkg.sv
// burst attribute types of the memory read and write channels
`default_nettype none

package cache_bus_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2   // wraps at the line boundary
    } burst_t;

    typedef logic [2:0] size_t;       // log2 of bytes per beat
    typedef logic [7:0] burst_len_t;  // beats minus one

endpackage

`default_nettype wire

//--- design/cache_ctrl.sv
// cache controller with hit check, victim choice, writeback and critical-word-first refill
`default_nettype none

`include "cache_params.svh"

module cache_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst,

    input  wire cache_addr_pkg::addr_t       cpu_addr,
    input  wire logic                        cpu_r_ready,   // read request level
    output wire logic [`CACHE_DATA_W-1:0]    cpu_r_data,
    output logic                             cpu_r_valid,
    input  wire logic                        cpu_w_valid,   // write request level
    input  wire logic [`CACHE_STRB_W-1:0]    cpu_w_strb,
    input  wire logic [`CACHE_DATA_W-1:0]    cpu_w_data,
    output logic                             cpu_w_ready,

    output wire cache_addr_pkg::index_t      index,
    output cache_addr_pkg::way_t             way,
    output cache_addr_pkg::offset_t          offset,
    output logic                             tag_w_en,
    output cache_addr_pkg::tag_entry_t       tag_w_data,
    input  wire cache_addr_pkg::tag_entry_t  tag0,
    input  wire cache_addr_pkg::tag_entry_t  tag1,
    input  wire cache_addr_pkg::tag_entry_t  tag2,
    input  wire cache_addr_pkg::tag_entry_t  tag3,
    output logic                             sram_w_en,
    output logic [`CACHE_STRB_W-1:0]         sram_w_strb,
    output logic [`CACHE_DATA_W-1:0]         sram_w_data,
    input  wire logic [`CACHE_DATA_W-1:0]    sram_r_data,

    output wire cache_addr_pkg::addr_t       mem_w_addr,
    output logic                             mem_w_valid,
    output wire logic [`CACHE_DATA_W-1:0]    mem_w_data,
    output wire logic [`CACHE_STRB_W-1:0]    mem_w_strb,
    output wire cache_bus_pkg::size_t        mem_w_size,
    output wire cache_bus_pkg::burst_t       mem_w_burst,
    output wire cache_bus_pkg::burst_len_t   mem_w_len,
    input  wire logic                        mem_w_ready,

    output wire cache_addr_pkg::addr_t       mem_r_addr,
    output logic                             mem_r_ready,
    input  wire logic                        mem_r_valid,
    input  wire logic [`CACHE_DATA_W-1:0]    mem_r_data,
    output wire cache_bus_pkg::size_t        mem_r_size,
    output wire cache_bus_pkg::burst_t       mem_r_burst,
    output wire cache_bus_pkg::burst_len_t   mem_r_len,

    output wire logic                        cache_busy
);
    import cache_addr_pkg::*;
    import cache_bus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_HIT,
        ST_WR_HIT,
        ST_WBACK,
        ST_REFILL
    } state_t;

    state_t     state;
    addr_t      addr_r;      // request address held across a miss
    addr_t      cur_addr;
    tag_t       req_tag;
    index_t     req_index;
    offset_t    req_off;
    way_t       way_r;       // hit way or victim
    logic       is_write;
    offset_t    beat_off;    // wraps inside the line
    word_sel_t  beat_cnt;
    logic [7:0] lfsr;
    logic       lfsr_fb;

    tag_entry_t entry [`CACHE_WAYS];
    logic       hit;
    way_t       hit_way;
    logic       has_free;
    way_t       free_way;
    way_t       victim_way;
    logic       req;
    logic       first_beat;
    logic       last_beat;
    logic [`CACHE_DATA_W-1:0] merged;

    assign cur_addr = (state == ST_IDLE) ? cpu_addr : addr_r;
    assign {req_tag, req_index, req_off} = cur_addr;

    assign entry[0] = tag0;
    assign entry[1] = tag1;
    assign entry[2] = tag2;
    assign entry[3] = tag3;

    assign req        = cpu_r_ready | cpu_w_valid;
    assign first_beat = (beat_cnt == '0);
    assign last_beat  = (beat_cnt == word_sel_t'(`CACHE_BEATS - 1));
    assign lfsr_fb    = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];  // x^8+x^6+x^5+x^4+1

    // lowest matching way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (entry[w].valid && entry[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    always_comb begin
        has_free = 1'b0;
        free_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!entry[w].valid) begin
                has_free = 1'b1;
                free_way = way_t'(w);
            end
        end
    end

    assign victim_way = has_free ? free_way : lfsr[1:0];  // random only when set is full

    // cpu bytes over the first returning beat of a write miss
    always_comb begin
        for (int b = 0; b < `CACHE_STRB_W; b++) begin
            merged[8*b +: 8] = cpu_w_strb[b] ? cpu_w_data[8*b +: 8] : mem_r_data[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            is_write <= 1'b0;
            beat_cnt <= '0;
            lfsr     <= 8'h01;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        is_write <= cpu_w_valid;
                        beat_cnt <= '0;
                        if (hit) begin
                            state <= cpu_w_valid ? ST_WR_HIT : ST_RD_HIT;
                        end else if (entry[victim_way].valid && entry[victim_way].dirty) begin
                            state <= ST_WBACK;
                        end else begin
                            state <= ST_REFILL;
                        end
                    end
                end
                ST_RD_HIT, ST_WR_HIT: state <= ST_IDLE;
                ST_WBACK: begin
                    if (mem_w_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;  // wraps back to 0 for the refill
                        if (last_beat) begin
                            state <= ST_REFILL;
                            lfsr  <= {lfsr[6:0], lfsr_fb};
                        end
                    end
                end
                ST_REFILL: begin
                    if (mem_r_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            addr_r   <= cpu_addr;
            way_r    <= hit ? hit_way : victim_way;
            beat_off <= {cpu_addr[5:3], 3'b000};  // requested word first
        end else if ((state == ST_WBACK && mem_w_ready) ||
                     (state == ST_REFILL && mem_r_valid)) begin
            beat_off <= beat_off + 6'd8;          // eight steps come back to the start
        end
    end

    always_comb begin
        cpu_r_valid = 1'b0;
        cpu_w_ready = 1'b0;
        way         = way_r;
        offset      = beat_off;
        tag_w_en    = 1'b0;
        tag_w_data  = '0;
        sram_w_en   = 1'b0;
        sram_w_strb = cpu_w_strb;
        sram_w_data = cpu_w_data;
        mem_w_valid = 1'b0;
        mem_r_ready = 1'b0;
        case (state)
            ST_IDLE: begin
                way    = hit_way;
                offset = req_off;
                if (cpu_w_valid && hit) begin  // write hit lands at the sampling edge
                    sram_w_en  = 1'b1;
                    tag_w_en   = 1'b1;
                    tag_w_data = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
                end
            end
            ST_RD_HIT: cpu_r_valid = 1'b1;
            ST_WR_HIT: cpu_w_ready = 1'b1;
            ST_WBACK: begin
                mem_w_valid = 1'b1;
                if (mem_w_ready && last_beat) begin
                    tag_w_en = 1'b1;  // victim invalid until refilled
                end
            end
            ST_REFILL: begin
                mem_r_ready = 1'b1;
                if (mem_r_valid) begin
                    sram_w_en   = 1'b1;
                    sram_w_strb = '1;
                    sram_w_data = (first_beat && is_write) ? merged : mem_r_data;
                    cpu_r_valid = first_beat && !is_write;
                    cpu_w_ready = first_beat && is_write;
                    if (last_beat) begin
                        tag_w_en   = 1'b1;
                        tag_w_data = '{valid: 1'b1, dirty: is_write, tag: req_tag};
                    end
                end
            end
            default: ;
        endcase
    end

    assign index      = req_index;
    assign cpu_r_data = (state == ST_REFILL) ? mem_r_data : sram_r_data;
    assign cache_busy = (state == ST_WBACK) || (state == ST_REFILL);

    // writeback goes to the line of the victim's stored tag
    assign mem_w_addr  = {entry[way_r].tag, req_index, req_off[5:3], 3'b000};
    assign mem_w_data  = sram_r_data;
    assign mem_w_strb  = '1;
    assign mem_w_size  = size_t'($clog2(`CACHE_STRB_W));
    assign mem_w_burst = BURST_WRAP;
    assign mem_w_len   = burst_len_t'(`CACHE_BEATS - 1);

    assign mem_r_addr  = {req_tag, req_index, req_off[5:3], 3'b000};
    assign mem_r_size  = size_t'($clog2(`CACHE_STRB_W));
    assign mem_r_burst = BURST_WRAP;
    assign mem_r_len   = burst_len_t'(`CACHE_BEATS - 1);

endmodule

`default_nettype wire

//--- design/cache_data_array.sv
// data array: line words per way and set, byte-strobe write, combinational read
`default_nettype none

`include "cache_params.svh"

module cache_data_array (
    input  wire logic                       clk,
    input  wire cache_addr_pkg::way_t       way,
    input  wire cache_addr_pkg::index_t     index,
    input  wire cache_addr_pkg::offset_t    offset,
    input  wire logic                       sram_w_en,
    input  wire logic [`CACHE_STRB_W-1:0]   sram_w_strb,
    input  wire logic [`CACHE_DATA_W-1:0]   sram_w_data,
    output wire logic [`CACHE_DATA_W-1:0]   sram_r_data
);
    import cache_addr_pkg::*;

    logic [`CACHE_DATA_W-1:0] words [`CACHE_WAYS][`CACHE_SETS][`CACHE_BEATS];
    word_sel_t                word;

    assign word = offset[5:3];  // low bits select a byte inside the word

    always_ff @(posedge clk) begin
        if (sram_w_en) begin
            for (int b = 0; b < `CACHE_STRB_W; b++) begin
                if (sram_w_strb[b]) begin
                    words[way][index][word][8*b +: 8] <= sram_w_data[8*b +: 8];
                end
            end
        end
    end

    assign sram_r_data = words[way][index][word];

endmodule

`default_nettype wire

//--- design/cache_params.svh
// cache geometry: widths, way/set counts and burst length for the 4 KB data cache
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

`define CACHE_ADDR_W 32  // byte address
`define CACHE_DATA_W 64  // cpu and memory word
`define CACHE_STRB_W 8   // one strobe per byte
`define CACHE_WAYS   4
`define CACHE_SETS   16
`define CACHE_BEATS  8   // words per line, also burst length
`define CACHE_TAG_W  22  // addr[31:10]

`endif

//--- design/cache_tag_array.sv
// tag array: valid, dirty and tag per set and way, all four ways read at once
`default_nettype none

`include "cache_params.svh"

module cache_tag_array (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire cache_addr_pkg::index_t    index,
    input  wire logic                      tag_w_en,
    input  wire cache_addr_pkg::way_t      way,
    input  wire cache_addr_pkg::tag_entry_t tag_w_data,
    output wire cache_addr_pkg::tag_entry_t tag0,
    output wire cache_addr_pkg::tag_entry_t tag1,
    output wire cache_addr_pkg::tag_entry_t tag2,
    output wire cache_addr_pkg::tag_entry_t tag3
);
    import cache_addr_pkg::*;

    tag_entry_t entries [`CACHE_SETS][`CACHE_WAYS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    entries[s][w] <= '0;  // all lines invalid
                end
            end
        end else if (tag_w_en) begin
            entries[index][way] <= tag_w_data;
        end
    end

    assign tag0 = entries[index][0];
    assign tag1 = entries[index][1];
    assign tag2 = entries[index][2];
    assign tag3 = entries[index][3];

endmodule

`default_nettype wire

//--- design/cache_top.sv
// data cache top: controller with tag and data arrays between cpu and memory ports
`default_nettype none

`include "cache_params.svh"

module cache_top (
    input  wire logic                      clk,
    input  wire logic                      rst,

    input  wire cache_addr_pkg::addr_t     cpu_addr,
    input  wire logic                      cpu_r_ready,
    output wire logic [`CACHE_DATA_W-1:0]  cpu_r_data,
    output wire logic                      cpu_r_valid,
    input  wire logic                      cpu_w_valid,
    input  wire logic [`CACHE_STRB_W-1:0]  cpu_w_strb,
    input  wire logic [`CACHE_DATA_W-1:0]  cpu_w_data,
    output wire logic                      cpu_w_ready,

    output wire cache_addr_pkg::addr_t     mem_w_addr,
    output wire logic                      mem_w_valid,
    output wire logic [`CACHE_DATA_W-1:0]  mem_w_data,
    output wire logic [`CACHE_STRB_W-1:0]  mem_w_strb,
    output wire cache_bus_pkg::size_t      mem_w_size,
    output wire cache_bus_pkg::burst_t     mem_w_burst,
    output wire cache_bus_pkg::burst_len_t mem_w_len,
    input  wire logic                      mem_w_ready,

    output wire cache_addr_pkg::addr_t     mem_r_addr,
    output wire logic                      mem_r_ready,
    input  wire logic                      mem_r_valid,
    input  wire logic [`CACHE_DATA_W-1:0]  mem_r_data,
    output wire cache_bus_pkg::size_t      mem_r_size,
    output wire cache_bus_pkg::burst_t     mem_r_burst,
    output wire cache_bus_pkg::burst_len_t mem_r_len,

    output wire logic                      cache_busy
);
    import cache_addr_pkg::*;

    // controller to arrays
    index_t                   index;
    way_t                     way;
    offset_t                  offset;
    logic                     tag_w_en;
    tag_entry_t               tag_w_data;
    tag_entry_t               tag0;
    tag_entry_t               tag1;
    tag_entry_t               tag2;
    tag_entry_t               tag3;
    logic                     sram_w_en;
    logic [`CACHE_STRB_W-1:0] sram_w_strb;
    logic [`CACHE_DATA_W-1:0] sram_w_data;
    logic [`CACHE_DATA_W-1:0] sram_r_data;

    cache_ctrl u_ctrl (.*);

    cache_tag_array u_tags (.*);  // shares index and way with the data array

    cache_data_array u_data (.*);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it; exit status is the test result
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module cache_tb -f build.f -o cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

//--- verif/cache_tb.sv
// data cache testbench with directed and random cpu traffic checked against a shadow memory
`default_nettype none

`include "cache_params.svh"

module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_addr_pkg::*;
    import cache_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 40000;  // about 330 requests of under 80 cycles with stalls

    logic                     clk = 1'b0;
    logic                     rst;
    addr_t                    cpu_addr;
    logic                     cpu_r_ready;
    logic [`CACHE_DATA_W-1:0] cpu_r_data;
    logic                     cpu_r_valid;
    logic                     cpu_w_valid;
    logic [`CACHE_STRB_W-1:0] cpu_w_strb;
    logic [`CACHE_DATA_W-1:0] cpu_w_data;
    logic                     cpu_w_ready;
    addr_t                    mem_w_addr;
    logic                     mem_w_valid;
    logic [`CACHE_DATA_W-1:0] mem_w_data;
    logic [`CACHE_STRB_W-1:0] mem_w_strb;
    size_t                    mem_w_size;
    burst_t                   mem_w_burst;
    burst_len_t               mem_w_len;
    logic                     mem_w_ready;
    addr_t                    mem_r_addr;
    logic                     mem_r_ready;
    logic                     mem_r_valid;
    logic [`CACHE_DATA_W-1:0] mem_r_data;
    size_t                    mem_r_size;
    burst_t                   mem_r_burst;
    burst_len_t               mem_r_len;
    logic                     cache_busy;

    int          cycles = 0;
    string       test_name;
    logic [31:0] rand_state;
    logic [63:0] shadow [logic [12:0]];  // cpu-written words by addr[15:3]
    logic        wb_lines [addr_t];      // lines seen on the write channel
    addr_t       refill_addr;
    int          refill_beats = 0;
    logic        r_ready_q = 1'b0;
    logic        w_valid_q = 1'b0;

    cache_top dut (.*);

    tb_mem_model mem (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the cache stopped answering after %0d cycles", cycles);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // burst monitor on both memory channels
    always @(posedge clk) begin
        if (mem_r_ready && !r_ready_q) begin
            refill_addr  <= mem_r_addr;
            refill_beats <= mem_r_valid ? 1 : 0;
        end else if (mem_r_ready && mem_r_valid) begin
            refill_beats <= refill_beats + 1;
        end
        if (mem_w_valid && !w_valid_q) begin
            wb_lines[mem_w_addr & ~32'h3f] = 1'b1;
        end
        r_ready_q <= mem_r_ready;
        w_valid_q <= mem_w_valid;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [63:0] initial_word(input addr_t a);
        logic [15:0] w;
        w = {a[15:3], 3'b000};
        return {w ^ 16'h5a3c, w, ~w, w + 16'h1357};
    endfunction

    function automatic logic [63:0] expected_word(input addr_t a);
        if (shadow.exists(a[15:3])) begin
            return shadow[a[15:3]];
        end
        return initial_word(a);
    endfunction

    function automatic addr_t make_addr(input int tag, input int idx, input int word);
        return (addr_t'(tag) << 10) | (addr_t'(idx) << 6) | (addr_t'(word) << 3);
    endfunction

    task automatic check_eq(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s, %s: expected %h actual %h",
                     test_name, what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (cache_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic cpu_read(input addr_t a, output logic [63:0] data, output int lat,
                            output logic busy_seen);
        wait_idle();
        cpu_addr    = a;
        cpu_r_ready = 1'b1;
        lat         = 0;
        busy_seen   = 1'b0;
        do begin
            @(negedge clk);
            lat++;
            busy_seen |= cache_busy;
        end while (!cpu_r_valid);
        data        = cpu_r_data;
        cpu_r_ready = 1'b0;
    endtask

    task automatic cpu_write(input addr_t a, input logic [63:0] d, input logic [7:0] strb,
                             output int lat);
        logic [63:0] merged;
        wait_idle();
        cpu_addr    = a;
        cpu_w_data  = d;
        cpu_w_strb  = strb;
        cpu_w_valid = 1'b1;
        lat         = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!cpu_w_ready);
        cpu_w_valid = 1'b0;  // data and strobes stay put for the merge edge
        merged = expected_word(a);
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = d[8*b +: 8];
            end
        end
        shadow[a[15:3]] = merged;
    endtask

    task automatic read_miss_then_hit();
        logic [63:0] d;
        int          lat;
        logic        busy;
        test_name = "read miss then hit";
        cpu_read(make_addr(24, 1, 5), d, lat, busy);
        check_eq("miss data", initial_word(make_addr(24, 1, 5)), d);
        cpu_read(make_addr(24, 1, 5), d, lat, busy);
        check_eq("hit data", initial_word(make_addr(24, 1, 5)), d);
        check_eq("hit latency", 64'd1, 64'(lat));
        check_eq("busy during hit", 64'd0, 64'(busy));
    endtask

    task automatic write_hit_strobes();
        logic [63:0] d;
        int          lat;
        logic        busy;
        test_name = "write hit with strobes";
        cpu_write(make_addr(24, 1, 5), 64'h1122_3344_5566_7788, 8'b1010_0101, lat);
        check_eq("write latency", 64'd1, 64'(lat));
        cpu_read(make_addr(24, 1, 5), d, lat, busy);
        check_eq("merged bytes", expected_word(make_addr(24, 1, 5)), d);
    endtask

    task automatic write_miss_allocate();
        logic [63:0] d;
        int          lat;
        logic        busy;
        test_name = "write miss allocate";
        cpu_write(make_addr(25, 2, 3), 64'hfeed_face_0bad_f00d, 8'b0011_1100, lat);
        for (int w = 0; w < 8; w++) begin
            cpu_read(make_addr(25, 2, w), d, lat, busy);
            check_eq("line word", expected_word(make_addr(25, 2, w)), d);
        end
    endtask

    task automatic evict_with_writeback();
        logic [63:0] d;
        int          lat;
        logic        busy;
        addr_t       a;
        test_name = "eviction with writeback";
        wb_lines.delete();
        check_eq("write burst type", 64'(BURST_WRAP), 64'(mem_w_burst));
        check_eq("write burst size", 64'd3, 64'(mem_w_size));
        check_eq("write burst length", 64'd7, 64'(mem_w_len));
        for (int k = 0; k < 6; k++) begin
            cpu_write(make_addr(16 + k, 9, k), {16'hd00d, 16'(k), 32'hbeef_cafe}, 8'hff, lat);
        end
        for (int k = 0; k < 6; k++) begin
            cpu_read(make_addr(16 + k, 9, k), d, lat, busy);
            check_eq("read back", expected_word(make_addr(16 + k, 9, k)), d);
        end
        check_eq("at least two writebacks", 64'd1, 64'(wb_lines.num() >= 2));
        for (int k = 0; k < 6; k++) begin
            if (wb_lines.exists(make_addr(16 + k, 9, 0))) begin
                for (int w = 0; w < 8; w++) begin
                    a = make_addr(16 + k, 9, w);
                    check_eq("backing store", expected_word(a), mem.store[a[15:3]]);
                end
            end
        end
    endtask

    task automatic critical_word_first();
        logic [63:0] d;
        int          lat;
        logic        busy;
        addr_t       a;
        test_name = "critical word first";
        check_eq("read burst type", 64'(BURST_WRAP), 64'(mem_r_burst));
        check_eq("read burst size", 64'd3, 64'(mem_r_size));
        check_eq("read burst length", 64'd7, 64'(mem_r_len));
        for (int w = 0; w < 8; w++) begin
            a = make_addr(32 + w, 7, w);
            cpu_read(a, d, lat, busy);
            check_eq("first word", expected_word(a), d);
            check_eq("refill address", 64'(a), 64'(refill_addr));
            wait_idle();
            check_eq("refill beats", 64'd8, 64'(refill_beats));
        end
    endtask

    task automatic random_mix();
        logic [63:0] d;
        int          lat;
        logic        busy;
        addr_t       a;
        test_name = "random mix";
        for (int n = 0; n < 300; n++) begin
            rand_state = xorshift32(rand_state);
            a = make_addr(int'(rand_state[2:0]), 4 * int'(rand_state[4:3]),
                          int'(rand_state[7:5]));
            if (rand_state[8]) begin
                cpu_write(a, {rand_state, ~rand_state ^ 32'(n)}, rand_state[16:9], lat);
            end else begin
                cpu_read(a, d, lat, busy);
                check_eq("random read", expected_word(a), d);
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        cpu_addr    = '0;
        cpu_r_ready = 1'b0;
        cpu_w_valid = 1'b0;
        cpu_w_strb  = '0;
        cpu_w_data  = '0;
        rand_state  = 32'h335e_6868;
        test_name   = "reset";
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_eq("outputs after reset", 64'd0,
                 64'({cpu_r_valid, cpu_w_ready, mem_w_valid, mem_r_ready, cache_busy}));
        read_miss_then_hit();
        write_hit_strobes();
        write_miss_allocate();
        evict_with_writeback();
        critical_word_first();
        random_mix();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_mem_model.sv
// burst memory model: 64 KB store, wrapping read and write bursts with random stalls
`default_nettype none

`include "cache_params.svh"

module tb_mem_model (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire cache_addr_pkg::addr_t     mem_w_addr,
    input  wire logic                      mem_w_valid,
    input  wire logic [`CACHE_DATA_W-1:0]  mem_w_data,
    input  wire logic [`CACHE_STRB_W-1:0]  mem_w_strb,
    input  wire cache_bus_pkg::burst_len_t mem_w_len,
    output logic                           mem_w_ready,
    input  wire cache_addr_pkg::addr_t     mem_r_addr,
    input  wire logic                      mem_r_ready,
    output logic                           mem_r_valid,
    output wire logic [`CACHE_DATA_W-1:0]  mem_r_data,
    input  wire cache_bus_pkg::burst_len_t mem_r_len
);
    timeunit 1ns;
    timeprecision 1ps;
    import cache_addr_pkg::*;
    import cache_bus_pkg::*;

    logic [`CACHE_DATA_W-1:0] store [8192];  // indexed by addr[15:3]
    logic [31:0] rng;
    logic        rd_busy;
    addr_t       rd_addr;
    burst_len_t  rd_cnt;
    logic        wr_busy;
    addr_t       wr_addr;
    burst_len_t  wr_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // start content, every field taken from the word's byte address
    function automatic logic [63:0] fill_word(input logic [12:0] widx);
        logic [15:0] w;
        w = {widx, 3'b000};
        return {w ^ 16'h5a3c, w, ~w, w + 16'h1357};
    endfunction

    // next word of a burst, wrapping inside the 64-byte line
    function automatic addr_t wrap_next(input addr_t a);
        return {a[31:6], a[5:3] + 3'd1, 3'b000};
    endfunction

    assign mem_r_data = store[rd_addr[15:3]];

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8192; i++) begin
                store[i] <= fill_word(13'(i));
            end
            rng         <= 32'h335e_6868;
            rd_busy     <= 1'b0;
            mem_r_valid <= 1'b0;
            wr_busy     <= 1'b0;
            mem_w_ready <= 1'b0;
        end else begin
            rng <= xorshift32(rng);
            if (!rd_busy) begin
                if (mem_r_ready) begin  // refill burst starts
                    rd_busy     <= 1'b1;
                    rd_addr     <= mem_r_addr;
                    rd_cnt      <= '0;
                    mem_r_valid <= rng[1:0] != 2'b00;  // about one stall in four
                end
            end else if (mem_r_valid && mem_r_ready && rd_cnt == mem_r_len) begin
                rd_busy     <= 1'b0;
                mem_r_valid <= 1'b0;
            end else begin
                if (mem_r_valid && mem_r_ready) begin
                    rd_addr <= wrap_next(rd_addr);
                    rd_cnt  <= rd_cnt + 8'd1;
                end
                mem_r_valid <= rng[1:0] != 2'b00;
            end
            if (!wr_busy) begin
                if (mem_w_valid) begin  // writeback burst starts
                    wr_busy     <= 1'b1;
                    wr_addr     <= mem_w_addr;
                    wr_cnt      <= '0;
                    mem_w_ready <= rng[3:2] != 2'b00;
                end
            end else begin
                if (mem_w_valid && mem_w_ready) begin
                    for (int b = 0; b < `CACHE_STRB_W; b++) begin
                        if (mem_w_strb[b]) begin
                            store[wr_addr[15:3]][8*b +: 8] <= mem_w_data[8*b +: 8];
                        end
                    end
                    wr_addr <= wrap_next(wr_addr);
                    wr_cnt  <= wr_cnt + 8'd1;
                end
                if (mem_w_valid && mem_w_ready && wr_cnt == mem_w_len) begin
                    wr_busy     <= 1'b0;
                    mem_w_ready <= 1'b0;
                end else begin
                    mem_w_ready <= rng[3:2] != 2'b00;
                end
            end
        end
    end

endmodule

`default_nettype wire
